//--- source/sata_oob_pkg.sv
package sata_oob_pkg;

    // One link word, K marks byte 0 as a control character
    typedef struct packed {
        logic [31:0] data;
        logic        k;
    } dword_t;

    typedef struct packed {
        logic rx_locked;      // Transceiver PLL locked
        logic tx_reset_done;
        logic rx_reset_done;
        logic cominit_det;    // Device COMINIT seen
        logic comwake_det;    // Device COMWAKE seen
        logic rx_elec_idle;
        logic byte_aligned;   // Comma alignment reached
    } phy_status_t;

    typedef struct packed {
        logic tx_cominit;     // COMRESET burst
        logic tx_comwake;     // COMWAKE burst
        logic tx_elec_idle;
        logic rx_reset;       // Receive PCS reset pulse
    } oob_ctrl_t;

    typedef enum logic [1:0] {
        FILL_ALIGN,
        FILL_D10_2,
        FILL_USER
    } fill_t;

    typedef enum logic [3:0] {
        HOST_COMRESET,
        WAIT_DEV_COMINIT,
        HOST_COMWAKE,
        WAIT_DEV_COMWAKE,
        WAIT_AFTER_COMWAKE,
        WAIT_RX_ACTIVE,
        HOST_D10_2,
        HOST_SEND_ALIGN,
        LINK_READY
    } oob_state_t;

    // Primitive codes, byte 0 is the K character
    localparam logic [31:0] PRIM_ALIGN   = 32'h7B4A_4ABC;
    localparam logic [31:0] PRIM_SYNC    = 32'hB5B5_957C;
    localparam logic [31:0] PRIM_CONT    = 32'h9999_AA7C;
    localparam logic [31:0] PRIM_HOLD    = 32'hD5D5_AA7C;
    localparam logic [31:0] PRIM_HOLDA   = 32'h9595_AA7C;
    localparam logic [31:0] PRIM_PMREQ_P = 32'h1717_B57C;
    localparam logic [31:0] PRIM_PMREQ_S = 32'h7575_957C;
    localparam logic [31:0] PRIM_R_ERR   = 32'h5656_B57C;
    localparam logic [31:0] PRIM_R_IP    = 32'h5555_B57C;
    localparam logic [31:0] PRIM_R_OK    = 32'h3535_B57C;
    localparam logic [31:0] PRIM_R_RDY   = 32'h4A4A_957C;
    localparam logic [31:0] PRIM_WTRM    = 32'h5858_B57C;
    localparam logic [31:0] PRIM_X_RDY   = 32'h5757_B57C;
    localparam logic [31:0] PRIM_SOF     = 32'h3737_B57C;

    localparam logic [31:0] DIAL_TONE    = 32'h4A4A_4A4A;  // D10.2 repeated, sent with K=0

    localparam int TIMER_WIDTH = 18;

    // Burst lengths in clock cycles per generation
    localparam logic [TIMER_WIDTH-1:0] COMRESET_CYCLES_GEN1 = TIMER_WIDTH'(81);
    localparam logic [TIMER_WIDTH-1:0] COMRESET_CYCLES_GEN2 = TIMER_WIDTH'(162);
    localparam logic [TIMER_WIDTH-1:0] COMRESET_CYCLES_GEN3 = TIMER_WIDTH'(324);
    localparam logic [TIMER_WIDTH-1:0] COMWAKE_CYCLES_GEN1  = TIMER_WIDTH'(78);
    localparam logic [TIMER_WIDTH-1:0] COMWAKE_CYCLES_GEN2  = TIMER_WIDTH'(155);
    localparam logic [TIMER_WIDTH-1:0] COMWAKE_CYCLES_GEN3  = TIMER_WIDTH'(310);

    localparam logic [TIMER_WIDTH-1:0] DEV_TIMEOUT_CYCLES   = TIMER_WIDTH'(132013);
    localparam logic [TIMER_WIDTH-1:0] SETTLE_CYCLES        = TIMER_WIDTH'(63);

    localparam int SYNC_COUNT_WIDTH = 6;
    localparam logic [SYNC_COUNT_WIDTH-1:0] SYNC_STABLE_COUNT = SYNC_COUNT_WIDTH'(50);

endpackage

//--- source/oob_sequencer.sv
module oob_sequencer
    import sata_oob_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [1:0]  gen,
    input  phy_status_t phy,
    input  logic        align_det,
    input  logic        sync_det,
    input  logic        sync_stable,
    output oob_ctrl_t   ctrl,
    output fill_t       fill,
    output logic        linkup
);

    oob_state_t             state;
    oob_state_t             next_state;
    logic [TIMER_WIDTH-1:0] timer;
    logic                   timer_run;
    logic [TIMER_WIDTH-1:0] comreset_len;
    logic [TIMER_WIDTH-1:0] comwake_len;
    oob_ctrl_t              ctrl_next;
    logic                   phy_ready;
    logic                   dev_timeout;

    assign phy_ready   = phy.rx_locked && phy.tx_reset_done && phy.rx_reset_done;
    assign dev_timeout = (timer == DEV_TIMEOUT_CYCLES);

    // Burst lengths per generation, gen must hold during OOB
    always_comb begin
        case (gen)
            2'd0: begin
                comreset_len = COMRESET_CYCLES_GEN1;
                comwake_len  = COMWAKE_CYCLES_GEN1;
            end
            2'd1: begin
                comreset_len = COMRESET_CYCLES_GEN2;
                comwake_len  = COMWAKE_CYCLES_GEN2;
            end
            default: begin
                comreset_len = COMRESET_CYCLES_GEN3;
                comwake_len  = COMWAKE_CYCLES_GEN3;
            end
        endcase
    end

    always_comb begin
        next_state             = state;
        timer_run              = 1'b0;
        ctrl_next.tx_cominit   = 1'b0;
        ctrl_next.tx_comwake   = 1'b0;
        ctrl_next.tx_elec_idle = 1'b1;
        ctrl_next.rx_reset     = 1'b0;

        case (state)
            HOST_COMRESET: begin
                if (phy_ready) begin
                    if (timer == comreset_len) begin
                        next_state = WAIT_DEV_COMINIT;
                    end else begin
                        timer_run            = 1'b1;
                        ctrl_next.tx_cominit = 1'b1;
                    end
                end
            end
            WAIT_DEV_COMINIT: begin
                if (phy.cominit_det) begin
                    next_state = HOST_COMWAKE;
                end else if (dev_timeout) begin
                    next_state = HOST_COMRESET;  // Device silent, retry
                end else begin
                    timer_run = 1'b1;
                end
            end
            HOST_COMWAKE: begin
                if (timer == comwake_len) begin
                    next_state = WAIT_DEV_COMWAKE;
                end else begin
                    timer_run            = 1'b1;
                    ctrl_next.tx_comwake = 1'b1;
                end
            end
            WAIT_DEV_COMWAKE: begin
                if (phy.comwake_det) begin
                    next_state = WAIT_AFTER_COMWAKE;
                end else if (dev_timeout) begin
                    next_state = HOST_COMRESET;
                end else begin
                    timer_run = 1'b1;
                end
            end
            WAIT_AFTER_COMWAKE: begin
                if (timer == SETTLE_CYCLES) begin
                    next_state = WAIT_RX_ACTIVE;
                end else begin
                    timer_run = 1'b1;
                end
            end
            WAIT_RX_ACTIVE: begin
                // No timeout here, the device owns the line
                if (!phy.rx_elec_idle) begin
                    ctrl_next.rx_reset     = 1'b1;
                    ctrl_next.tx_elec_idle = 1'b0;
                    next_state             = HOST_D10_2;
                end
            end
            HOST_D10_2: begin
                ctrl_next.tx_elec_idle = 1'b0;
                if (align_det) begin
                    next_state = HOST_SEND_ALIGN;
                end else if (dev_timeout) begin
                    next_state = HOST_COMRESET;
                end else begin
                    timer_run = 1'b1;
                end
            end
            HOST_SEND_ALIGN: begin
                ctrl_next.tx_elec_idle = 1'b0;
                if (sync_det) begin
                    next_state = LINK_READY;
                end
            end
            LINK_READY: begin
                ctrl_next.tx_elec_idle = 1'b0;  // Terminal until reset
            end
            default: begin
                next_state = HOST_COMRESET;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= HOST_COMRESET;
            timer <= '0;
        end else begin
            state <= next_state;
            timer <= timer_run ? timer + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl.tx_cominit   <= 1'b0;
            ctrl.tx_comwake   <= 1'b0;
            ctrl.tx_elec_idle <= 1'b1;
            ctrl.rx_reset     <= 1'b0;
            linkup            <= 1'b0;
        end else begin
            ctrl   <= ctrl_next;
            linkup <= (state == LINK_READY) && sync_stable;
        end
    end

    always_comb begin
        case (state)
            HOST_D10_2: fill = FILL_D10_2;
            LINK_READY: fill = linkup ? FILL_USER : FILL_ALIGN;
            default:    fill = FILL_ALIGN;
        endcase
    end

    // Bursts are strictly sequential on the line
    assert property (@(posedge clk) disable iff (reset)
        !(ctrl.tx_cominit && ctrl.tx_comwake))
        else $error("tx_cominit and tx_comwake high together");

    assert property (@(posedge clk) disable iff (reset)
        ctrl.rx_reset |=> !ctrl.rx_reset)
        else $error("rx_reset longer than one cycle");

endmodule

//--- source/rx_cont_filter.sv
module rx_cont_filter
    import sata_oob_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  dword_t rx_in,
    input  logic   byte_aligned,
    output dword_t rx_raw,
    output dword_t rx_filtered,
    output logic   align_det,
    output logic   sync_det,
    output logic   sync_stable
);

    logic                        cont_det;
    logic                        cont_flag;
    logic                        raw_listed;
    logic                        hold;
    logic [SYNC_COUNT_WIDTH-1:0] sync_count;

    // Primitives that end a CONT run
    function automatic logic is_listed(input dword_t w);
        return w.k && (w.data inside {PRIM_HOLD, PRIM_HOLDA, PRIM_PMREQ_P, PRIM_PMREQ_S,
                                      PRIM_R_ERR, PRIM_R_IP, PRIM_R_OK, PRIM_R_RDY,
                                      PRIM_WTRM, PRIM_X_RDY, PRIM_SOF});
    endfunction

    always_ff @(posedge clk) begin
        rx_raw <= rx_in;
    end

    assign align_det  = rx_raw.k && (rx_raw.data == PRIM_ALIGN) && byte_aligned;
    assign sync_det   = rx_raw.k && (rx_raw.data == PRIM_SYNC);
    assign cont_det   = rx_raw.k && (rx_raw.data == PRIM_CONT);
    assign raw_listed = is_listed(rx_raw);
    assign hold       = cont_det || (cont_flag && !raw_listed);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cont_flag <= 1'b0;
        end else if (cont_det) begin
            cont_flag <= 1'b1;
        end else if (raw_listed) begin
            cont_flag <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_filtered <= '0;
        end else if (!hold) begin
            rx_filtered <= rx_raw;  // Otherwise repeat last primitive
        end
    end

    // Stability counter, sticky once set
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_count  <= '0;
            sync_stable <= 1'b0;
        end else if (!sync_stable) begin
            if (rx_filtered.k && (rx_filtered.data == PRIM_SYNC)) begin
                if (sync_count == SYNC_STABLE_COUNT) begin
                    sync_stable <= 1'b1;
                end else begin
                    sync_count <= sync_count + 1'b1;
                end
            end else begin
                sync_count <= '0;
            end
        end
    end

    // Inside a CONT run only a listed primitive may replace the held word
    assert property (@(posedge clk) disable iff (reset)
        cont_flag |=> $stable(rx_filtered) || is_listed(rx_filtered))
        else $error("rx_filtered changed to %h inside CONT run", rx_filtered.data);

endmodule

//--- source/port_mux.sv
module port_mux
    import sata_oob_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  fill_t  fill,
    input  logic   linkup,
    input  dword_t tx_in,
    input  dword_t rx_raw,
    input  dword_t rx_filtered,
    output dword_t tx_out,
    output dword_t rx_out
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_out <= '0;
        end else begin
            case (fill)
                FILL_D10_2: begin
                    tx_out.data <= DIAL_TONE;
                    tx_out.k    <= 1'b0;
                end
                FILL_USER: begin
                    tx_out <= tx_in;  // Link up, user data
                end
                default: begin
                    tx_out.data <= PRIM_ALIGN;
                    tx_out.k    <= 1'b1;
                end
            endcase
        end
    end

    // CONT suppression only once the link is up
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_out <= '0;
        end else begin
            rx_out <= linkup ? rx_filtered : rx_raw;
        end
    end

endmodule

//--- source/oob_link.sv
module oob_link
    import sata_oob_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [1:0]  gen,       // 0 gen1, 1 gen2, 2 and 3 gen3
    input  phy_status_t phy,
    output oob_ctrl_t   ctrl,
    input  dword_t      rx_in,     // From transceiver
    output dword_t      rx_out,    // To link layer
    input  dword_t      tx_in,     // From link layer
    output dword_t      tx_out,    // To transceiver
    output logic        linkup
);

    fill_t  fill;
    logic   align_det;
    logic   sync_det;
    logic   sync_stable;
    dword_t rx_raw;
    dword_t rx_filtered;

    oob_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .gen         (gen),
        .phy         (phy),
        .align_det   (align_det),
        .sync_det    (sync_det),
        .sync_stable (sync_stable),
        .ctrl        (ctrl),
        .fill        (fill),
        .linkup      (linkup)
    );

    rx_cont_filter u_rx_filter (
        .clk          (clk),
        .reset        (reset),
        .rx_in        (rx_in),
        .byte_aligned (phy.byte_aligned),
        .rx_raw       (rx_raw),
        .rx_filtered  (rx_filtered),
        .align_det    (align_det),
        .sync_det     (sync_det),
        .sync_stable  (sync_stable)
    );

    port_mux u_port_mux (
        .clk         (clk),
        .reset       (reset),
        .fill        (fill),
        .linkup      (linkup),
        .tx_in       (tx_in),
        .rx_raw      (rx_raw),
        .rx_filtered (rx_filtered),
        .tx_out      (tx_out),
        .rx_out      (rx_out)
    );

endmodule

//--- bench/device_model.sv
module device_model
    import sata_oob_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  oob_ctrl_t   ctrl,
    input  dword_t      tx_out,
    input  logic        silent,       // Suppress COMINIT and COMWAKE replies
    input  logic        script_en,    // Replace the stream with script_word
    input  dword_t      script_word,
    output phy_status_t phy,
    output dword_t      rx_in,
    output int          sync_sent
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int REPLY_DELAY = 20;
    localparam int IDLE_DELAY  = 10;

    int   cominit_wait;
    int   comwake_wait;
    int   idle_wait;
    logic last_cominit;
    logic last_comwake;
    logic dial_seen;
    logic align_seen;

    task automatic clear_state();
        phy          = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
        rx_in        = '0;
        sync_sent    = 0;
        cominit_wait = 0;
        comwake_wait = 0;
        idle_wait    = 0;
        last_cominit = 1'b0;
        last_comwake = 1'b0;
        dial_seen    = 1'b0;
        align_seen   = 1'b0;
    endtask

    initial clear_state();

    always @(posedge clk) begin
        #2;
        if (reset) begin
            clear_state();
        end else begin
            phy.cominit_det = 1'b0;
            phy.comwake_det = 1'b0;
            if (idle_wait > 0) begin
                idle_wait--;
                if (idle_wait == 0) phy.rx_elec_idle = 1'b0;  // Device starts talking
            end
            if (last_cominit && !ctrl.tx_cominit) begin
                cominit_wait = REPLY_DELAY;
            end else if (cominit_wait > 0) begin
                cominit_wait--;
                if (cominit_wait == 0 && !silent) phy.cominit_det = 1'b1;
            end
            if (last_comwake && !ctrl.tx_comwake) begin
                comwake_wait = REPLY_DELAY;
            end else if (comwake_wait > 0) begin
                comwake_wait--;
                if (comwake_wait == 0 && !silent) begin
                    phy.comwake_det = 1'b1;
                    idle_wait       = IDLE_DELAY;
                end
            end
            last_cominit = ctrl.tx_cominit;
            last_comwake = ctrl.tx_comwake;
            if (!tx_out.k && tx_out.data == DIAL_TONE) dial_seen = 1'b1;
            else if (dial_seen && tx_out.k && tx_out.data == PRIM_ALIGN) align_seen = 1'b1;
            if (script_en) begin
                rx_in = script_word;
            end else if (phy.rx_elec_idle || !dial_seen) begin
                rx_in = '0;
            end else if (!align_seen) begin
                rx_in = '{data: PRIM_ALIGN, k: 1'b1};  // Answer to the dial tone
            end else begin
                rx_in = '{data: PRIM_SYNC, k: 1'b1};
                sync_sent++;
            end
        end
    end

endmodule

//--- bench/tb_oob_link.sv
module tb_oob_link
    import sata_oob_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES  = 4;
    localparam int BRINGUP_LIMIT = 4000;

    logic        clk;
    logic        reset;
    logic [1:0]  gen;
    phy_status_t phy;
    oob_ctrl_t   ctrl;
    dword_t      rx_in;
    dword_t      rx_out;
    dword_t      tx_in;
    dword_t      tx_out;
    logic        linkup;
    logic        silent;
    logic        script_en;
    dword_t      script_word;
    int          sync_sent;
    int          seed;
    int          run_cycles;
    int          cominit_len;
    int          comwake_len;
    int          idle_gap;
    logic        dial_seen;
    logic        rx_reset_seen;
    logic        tx_is_dial;
    logic        tx_is_align;
    logic        rx_is_align;

    oob_link DUT (.clk(clk), .reset(reset), .gen(gen), .phy(phy), .ctrl(ctrl), .rx_in(rx_in),
        .rx_out(rx_out), .tx_in(tx_in), .tx_out(tx_out), .linkup(linkup));

    device_model device (.clk(clk), .reset(reset), .ctrl(ctrl), .tx_out(tx_out),
        .silent(silent), .script_en(script_en), .script_word(script_word), .phy(phy),
        .rx_in(rx_in), .sync_sent(sync_sent));

    initial clk = 1'b0;
    always #10 clk = ~clk;

    assign tx_is_dial  = !tx_out.k && tx_out.data == DIAL_TONE;
    assign tx_is_align = tx_out.k && tx_out.data == PRIM_ALIGN;
    assign rx_is_align = rx_in.k && rx_in.data == PRIM_ALIGN;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic int comreset_expected(input logic [1:0] g);
        return g == 2'd0 ? 81 : (g == 2'd1 ? 162 : 324);
    endfunction

    function automatic int comwake_expected(input logic [1:0] g);
        return g == 2'd0 ? 78 : (g == 2'd1 ? 155 : 310);
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #2 reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;
    endtask

    // which: 0 tx_cominit, 1 tx_comwake, 2 linkup
    task automatic wait_level(input int which, input logic level, input int limit);
        int n;
        logic v;
        string name;
        n = 0;
        name = which == 0 ? "tx_cominit" : (which == 1 ? "tx_comwake" : "linkup");
        v = which == 0 ? ctrl.tx_cominit : (which == 1 ? ctrl.tx_comwake : linkup);
        while (v !== level && n < limit) begin
            @(posedge clk);
            #1;
            n++;
            v = which == 0 ? ctrl.tx_cominit : (which == 1 ? ctrl.tx_comwake : linkup);
        end
        if (v !== level) begin
            report_fail($sformatf("Timeout waiting for %s to reach %0d", name, level));
        end
    endtask

    task automatic send_script(input logic [31:0] data, input logic k);
        @(posedge clk);
        #1;
        script_en   = 1'b1;
        script_word = '{data: data, k: k};
    endtask

    always @(posedge clk) begin
        #2;
        tx_in.data = $random(seed);
        tx_in.k    = 1'b0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run_cycles    <= 0;
            cominit_len   <= 0;
            comwake_len   <= 0;
            idle_gap      <= 0;
            dial_seen     <= 1'b0;
            rx_reset_seen <= 1'b0;
        end else begin
            run_cycles  <= run_cycles + 1;
            cominit_len <= ctrl.tx_cominit ? cominit_len + 1 : 0;
            comwake_len <= ctrl.tx_comwake ? comwake_len + 1 : 0;
            idle_gap    <= ctrl.tx_cominit ? 0 : idle_gap + 1;
            if (tx_is_dial) dial_seen <= 1'b1;
            if (ctrl.rx_reset) rx_reset_seen <= 1'b1;
        end
    end

    // Burst widths per gen
    assert property (@(posedge clk) disable iff (reset)
        $fell(ctrl.tx_cominit) |-> cominit_len == comreset_expected(gen))
        else report_fail($sformatf("CHECK FAILED tx_cominit width %h expected %h",
            $sampled(cominit_len), comreset_expected(gen)));
    assert property (@(posedge clk) disable iff (reset)
        $fell(ctrl.tx_comwake) |-> comwake_len == comwake_expected(gen))
        else report_fail($sformatf("CHECK FAILED tx_comwake width %h expected %h",
            $sampled(comwake_len), comwake_expected(gen)));
    // Silent device
    assert property (@(posedge clk) disable iff (reset)
        silent |-> idle_gap <= int'(DEV_TIMEOUT_CYCLES) + 4 && !ctrl.tx_comwake)
        else report_fail("COMRESET did not restart in time or COMWAKE sent without a device");
    // Electrical idle and PCS reset
    assert property (@(posedge clk) disable iff (reset)
        $fell(ctrl.tx_elec_idle) |-> ctrl.rx_reset)
        else report_fail("tx_elec_idle left high without rx_reset");
    assert property (@(posedge clk) disable iff (reset)
        ctrl.rx_reset |-> !phy.rx_elec_idle ##1 !ctrl.rx_reset)
        else report_fail("rx_reset not a single pulse after receive line activity");
    // Dial tone then ALIGN
    assert property (@(posedge clk) disable iff (reset)
        rx_reset_seen && !linkup && !$past(linkup) |-> tx_is_dial || tx_is_align)
        else report_fail($sformatf("CHECK FAILED tx_out %h expected DIAL_TONE or ALIGN",
            $sampled(tx_out.data)));
    assert property (@(posedge clk) disable iff (reset)
        !linkup && $past(tx_is_dial) && tx_is_align |-> $past(rx_is_align, 3))
        else report_fail("tx_out left dial tone before ALIGN was received");
    assert property (@(posedge clk) disable iff (reset)
        !linkup && dial_seen && tx_is_align |=> !tx_is_dial)
        else report_fail("tx_out went back to dial tone after ALIGN");
    assert property (@(posedge clk) disable iff (reset)
        run_cycles >= 2 && !$past(linkup) |-> rx_out.data == $past(rx_in.data, 2)
            && rx_out.k == $past(rx_in.k, 2))
        else report_fail($sformatf("CHECK FAILED rx_out %h expected %h",
            $sampled(rx_out.data), $past(rx_in.data, 2)));
    // Link up
    assert property (@(posedge clk) disable iff (reset)
        $rose(linkup) |-> sync_sent >= 51 && sync_sent <= 59)
        else report_fail($sformatf("CHECK FAILED linkup after SYNC count %h expected 33 to 3b",
            $sampled(sync_sent)));
    assert property (@(posedge clk) disable iff (reset)
        $past(linkup) |-> linkup && tx_out == $past(tx_in))
        else report_fail($sformatf("CHECK FAILED tx_out %h expected %h",
            $sampled(tx_out.data), $past(tx_in.data)));
    // CONT run holds R_RDY until X_RDY
    assert property (@(posedge clk) disable iff (reset)
        run_cycles >= 4 && $past(script_en, 3) |-> rx_out.data ==
            ($past(rx_in.data, 3) == PRIM_X_RDY ? PRIM_X_RDY : PRIM_R_RDY))
        else report_fail($sformatf("CHECK FAILED rx_out %h during CONT run",
            $sampled(rx_out.data)));

    initial begin
        int g;
        seed        = 28061;
        reset       = 1'b1;
        gen         = 2'd0;
        silent      = 1'b0;
        script_en   = 1'b0;
        script_word = '0;
        tx_in       = '0;
        for (g = 0; g < 3; g++) begin
            gen = g[1:0];
            apply_reset();
            wait_level(0, 1'b1, 100);
            wait_level(0, 1'b0, 400);
            wait_level(1, 1'b1, 200);
            wait_level(1, 1'b0, 400);
            wait_level(2, 1'b1, BRINGUP_LIMIT);
        end
        repeat (40) @(posedge clk);
        send_script(PRIM_R_RDY, 1'b1);
        send_script(PRIM_CONT, 1'b1);
        repeat (12) send_script($random(seed), 1'b0);
        repeat (4) send_script(PRIM_X_RDY, 1'b1);
        @(posedge clk);
        #1 script_en = 1'b0;
        repeat (10) @(posedge clk);
        silent = 1'b1;
        apply_reset();
        wait_level(0, 1'b1, 100);
        wait_level(0, 1'b0, 400);
        wait_level(0, 1'b1, int'(DEV_TIMEOUT_CYCLES) + 8);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- sim.f
source/sata_oob_pkg.sv
source/oob_sequencer.sv
source/rx_cont_filter.sv
source/port_mux.sv
source/oob_link.sv
bench/device_model.sv
bench/tb_oob_link.sv

//--- Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_oob_link -o vsim
	./obj_dir/vsim | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
